//--- verilog.f
+incdir+logic
logic/lw_pkg.sv
logic/walk_control.sv
logic/record_reader.sv
logic/record_hash.sv
logic/result_writer.sv
logic/mem_arbiter.sv
logic/list_walker_top.sv
verification/list_checker.sv
verification/tb_list_walker.sv

//--- run.sh
#!/bin/sh
# Build and run the list walker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_list_walker -o sim_list_walker

out=$(./obj_dir/sim_list_walker)
echo "$out"

if echo "$out" | grep -qx "NO ERRORS"; then
    exit 0
else
    exit 1
fi

//--- verification/tb_list_walker.sv
`include "lw_config.svh"

`default_nettype none

// Testbench of the linked-list walker. It builds record chains in a memory
// model, starts walks over the host handshake and hands the expected
// results to the checker
module tb_list_walker
    import lw_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // About 60 records in all, 4 reads each, at most 12 cycles per read.
    // That is under 3000 cycles, so the limit leaves a wide margin
    localparam int MAX_RECORDS     = 60;
    localparam int CYCLES_PER_READ = 12;
    localparam int WALK_CYCLES     = MAX_RECORDS * `LW_RECORD_WORDS * CYCLES_PER_READ;
    localparam int TIMEOUT_CYCLES  = 40000;

    logic     clk;
    logic     reset;
    logic     start_req;
    lw_addr_t start_addr;
    lw_addr_t result_addr;
    logic     start_ack;
    lw_addr_t list_length;
    lw_addr_t data_count;
    logic     mem_req;
    logic     mem_we;
    lw_addr_t mem_addr;
    lw_word_t mem_wdata;
    logic     mem_ack;
    lw_word_t mem_rdata;

    // Expected results of the walk in progress
    logic [8*24-1:0] test_name;
    lw_word_t        exp_hash;
    lw_addr_t        exp_length;
    lw_addr_t        exp_count;
    lw_addr_t        exp_result;

    lw_word_t mem [0:65535];
    lw_addr_t node_addr [0:15];
    int       node_total;
    int       walks_run = 0;
    int       tb_errors = 0;
    int       checker_errors;
    int       walks_checked;
    int       cycle_count = 0;

    list_walker_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .start_req   (start_req),
        .start_addr  (start_addr),
        .result_addr (result_addr),
        .start_ack   (start_ack),
        .list_length (list_length),
        .data_count  (data_count),
        .mem_req     (mem_req),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata)
    );

    list_checker i_checker (
        .clk           (clk),
        .reset         (reset),
        .test_name     (test_name),
        .exp_hash      (exp_hash),
        .exp_length    (exp_length),
        .exp_count     (exp_count),
        .exp_result    (exp_result),
        .start_ack     (start_ack),
        .list_length   (list_length),
        .data_count    (data_count),
        .mem_req       (mem_req),
        .mem_we        (mem_we),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_ack       (mem_ack),
        .error_count   (checker_errors),
        .walks_checked (walks_checked)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ========================================================================
    // Memory model with a random ack delay per transaction
    // ========================================================================

    initial
    begin
        int delay;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        // A stray read returns a word that depends on its whole address
        for (int i = 0; i < 65536; i++)
            mem[lw_addr_t'(i)] = lw_word_t'(i) * 32'h9E3779B1;
        forever
        begin
            @(negedge clk);
            if (mem_req && !mem_ack)
            begin
                delay = $urandom_range(0, 7);
                repeat (delay) @(negedge clk);
                if (mem_we)
                    mem[mem_addr] = mem_wdata;
                else
                    mem_rdata = mem[mem_addr];
                mem_ack = 1'b1;
            end
            else if (!mem_req && mem_ack)
            begin
                mem_ack = 1'b0;
            end
        end
    end

    // Walks the chain in the model from the seed, rotating the hash left and
    // XORing in each data word up to the record whose link is zero
    function automatic void reference_walk(input lw_addr_t start, output lw_word_t hash,
                                           output lw_addr_t records, output lw_addr_t words);
        lw_addr_t addr;
        lw_addr_t link;
        int       guard;
        hash    = `LW_HASH_SEED;
        records = '0;
        words   = '0;
        addr    = start;
        guard   = 0;
        do
        begin
            link    = mem[addr][`LW_ADDR_W-1:0];
            records = records + lw_addr_t'(1);
            for (int w = 1; w < `LW_RECORD_WORDS; w++)
            begin
                hash  = {hash[`LW_WORD_W-`LW_HASH_ROT-1:0],
                         hash[`LW_WORD_W-1:`LW_WORD_W-`LW_HASH_ROT]} ^ mem[addr + lw_addr_t'(w)];
                words = words + lw_addr_t'(1);
            end
            addr  = link;
            guard++;
        end
        while (link != '0 && guard < 64);
    endfunction

    // Chains node_addr in order with random data and noisy upper link bits
    task automatic link_nodes();
        lw_word_t link;
        for (int i = 0; i < node_total; i++)
        begin
            link = $urandom;
            link[`LW_ADDR_W-1:0] = (i == node_total - 1) ? '0 : node_addr[i + 1];
            mem[node_addr[i]] = link;
            for (int w = 1; w < `LW_RECORD_WORDS; w++)
                mem[node_addr[i] + lw_addr_t'(w)] = $urandom;
        end
    endtask

    // Each record gets its own 256-word slot and a random aligned offset in it
    task automatic place_random_nodes(input int count, input int region);
        node_total = count;
        for (int i = 0; i < count; i++)
            node_addr[i] = lw_addr_t'(region + 256 * i + 4 * int'($urandom_range(0, 63)));
    endtask

    // Reports an output that has left its reset value
    task automatic expect_reset_value(input string what, input lw_word_t actual);
        if (actual !== '0)
        begin
            $display("[FAIL] %0s: %0s expected %h actual %h",
                     test_name, what, lw_word_t'(0), actual);
            tb_errors++;
        end
    endtask

    task automatic run_walk(input lw_addr_t start, input lw_addr_t result);
        lw_word_t hash;
        lw_addr_t records;
        lw_addr_t words;
        reference_walk(start, hash, records, words);
        @(negedge clk);
        exp_hash    = hash;
        exp_length  = records;
        exp_count   = words;
        exp_result  = result;
        start_addr  = start;
        result_addr = result;
        start_req   = 1'b1;
        while (!start_ack)
            @(negedge clk);
        start_req = 1'b0;
        while (start_ack)
            @(negedge clk);
        walks_run++;
    endtask

    initial
    begin
        void'($urandom(45));
        reset       = 1'b1;
        start_req   = 1'b0;
        start_addr  = '0;
        result_addr = '0;
        test_name   = "reset";
        exp_hash    = '0;
        exp_length  = '0;
        exp_count   = '0;
        exp_result  = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        // Handshake, memory request and both counts start out at zero
        expect_reset_value("start_ack", lw_word_t'(start_ack));
        expect_reset_value("mem_req", lw_word_t'(mem_req));
        expect_reset_value("list_length", lw_word_t'(list_length));
        expect_reset_value("data_count", lw_word_t'(data_count));

        test_name = "single record";
        node_total = 1;
        node_addr[0] = 16'h0100;
        link_nodes();
        run_walk(node_addr[0], 16'hF000);

        test_name = "five scattered records";
        node_total = 5;
        node_addr[0] = 16'h7F00;
        node_addr[1] = 16'h0344;
        node_addr[2] = 16'hC010;
        node_addr[3] = 16'h1200;
        node_addr[4] = 16'h0058;
        link_nodes();
        run_walk(node_addr[0], 16'hF010);

        test_name = "random list";
        for (int t = 0; t < 4; t++)
        begin
            place_random_nodes($urandom_range(1, 12), 'h2000);
            link_nodes();
            run_walk(node_addr[0], 16'hF020);
        end

        // Second walk follows at once and must not carry over the first
        test_name = "back to back first";
        place_random_nodes(3, 'h4000);
        link_nodes();
        run_walk(node_addr[0], 16'hF100);
        test_name = "back to back second";
        place_random_nodes(2, 'h5000);
        link_nodes();
        run_walk(node_addr[0], 16'hF200);

        @(negedge clk);
        if (walks_checked != walks_run)
        begin
            $display("Checker saw %0d walks but %0d were run", walks_checked, walks_run);
            tb_errors++;
        end
        $display("Walks run: %0d, checker errors: %0d, other errors: %0d",
                 walks_run, checker_errors, tb_errors);
        if (checker_errors == 0 && tb_errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    initial
    begin
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, walks expected to need about %0d",
                 cycle_count, WALK_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/list_checker.sv
`include "lw_config.svh"

`default_nettype none

// Watches the walker's memory port and its start handshake. Result writes
// are collected while a walk runs and are checked when start_ack rises
module list_checker
    import lw_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire logic [8*24-1:0] test_name,
    input  wire lw_word_t        exp_hash,
    input  wire lw_addr_t        exp_length,
    input  wire lw_addr_t        exp_count,
    input  wire lw_addr_t        exp_result,
    input  wire logic            start_ack,
    input  wire lw_addr_t        list_length,
    input  wire lw_addr_t        data_count,
    input  wire logic            mem_req,
    input  wire logic            mem_we,
    input  wire lw_addr_t        mem_addr,
    input  wire lw_word_t        mem_wdata,
    input  wire logic            mem_ack,
    output int                   error_count,
    output int                   walks_checked
);
    timeunit 1ns;
    timeprecision 1ps;

    // Only the hash write and the flag write are expected in one walk
    lw_addr_t wr_addr [0:1];
    lw_word_t wr_data [0:1];
    int       wr_count = 0;
    int       errors = 0;
    int       walks = 0;
    logic     ack_seen = 1'b0;
    logic     start_ack_seen = 1'b0;

    assign error_count   = errors;
    assign walks_checked = walks;

    task automatic compare_value(input string what, input lw_word_t expected,
                                 input lw_word_t actual);
        if (expected !== actual)
        begin
            $display("[FAIL] %0s: %0s expected %h actual %h",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    // ========================================================================
    // End-of-walk comparison
    // ========================================================================

    task automatic check_walk();
        if (wr_count != 2)
        begin
            $display("%0s: start_ack rose after %0d result writes instead of two",
                     test_name, wr_count);
            errors++;
        end
        else
        begin
            // The hash must land first, one word above the flag
            if (wr_addr[0] != exp_result + lw_addr_t'(1))
            begin
                $display("%0s: first result write went to address %h, not to %h",
                         test_name, wr_addr[0], exp_result + lw_addr_t'(1));
                errors++;
            end
            compare_value("hash word", exp_hash, wr_data[0]);
            if (wr_addr[1] != exp_result)
            begin
                $display("%0s: second result write went to address %h, not to %h",
                         test_name, wr_addr[1], exp_result);
                errors++;
            end
            compare_value("flag word", lw_word_t'(1), wr_data[1]);
        end
        compare_value("list_length", lw_word_t'(exp_length), lw_word_t'(list_length));
        compare_value("data_count", lw_word_t'(exp_count), lw_word_t'(data_count));
        wr_count = 0;
        walks++;
    endtask

    always @(posedge clk)
    begin
        if (reset)
        begin
            wr_count       = 0;
            ack_seen       = 1'b0;
            start_ack_seen = 1'b0;
        end
        else
        begin
            // A write counts once, in the cycle its ack is first seen
            if (mem_req && mem_we && mem_ack && !ack_seen)
            begin
                if (wr_count < 2)
                begin
                    wr_addr[wr_count] = mem_addr;
                    wr_data[wr_count] = mem_wdata;
                end
                else
                begin
                    $display("%0s: unexpected extra write of %h to address %h",
                             test_name, mem_wdata, mem_addr);
                    errors++;
                end
                wr_count++;
            end
            if (start_ack && !start_ack_seen)
                check_walk();
            ack_seen       = mem_ack;
            start_ack_seen = start_ack;
        end
    end

endmodule

`default_nettype wire

//--- logic/list_walker_top.sv
`default_nettype none

// Linked-list walker: follows a record chain, hashes the data words and
// writes the hash and a done flag back to memory
module list_walker_top
    import lw_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     start_req,
    input  wire lw_addr_t start_addr,
    input  wire lw_addr_t result_addr,
    output logic          start_ack,
    output lw_addr_t      list_length,
    output lw_addr_t      data_count,
    output logic          mem_req,
    output logic          mem_we,
    output lw_addr_t      mem_addr,
    output lw_word_t      mem_wdata,
    input  wire logic     mem_ack,
    input  wire lw_word_t mem_rdata
);

    // Sequencing between the FSM and the two masters
    logic     read_go;
    lw_addr_t read_addr;
    logic     write_go;
    lw_addr_t write_addr;
    logic     walk_clear;
    logic     reader_done;
    logic     list_end;
    lw_addr_t next_addr;
    logic     writer_done;

    // Reader side of the arbiter
    logic     rd_req;
    lw_addr_t rd_addr;
    logic     rd_ack;
    lw_word_t rd_rdata;

    // Writer side of the arbiter
    logic     wr_req;
    lw_addr_t wr_addr;
    lw_word_t wr_wdata;
    logic     wr_ack;

    // Data words on their way to the hash
    logic     data_valid;
    lw_word_t data_word;
    lw_word_t hash_value;

    walk_control i_walk_control (
        .clk         (clk),
        .reset       (reset),
        .start_req   (start_req),
        .start_addr  (start_addr),
        .result_addr (result_addr),
        .reader_done (reader_done),
        .list_end    (list_end),
        .next_addr   (next_addr),
        .writer_done (writer_done),
        .start_ack   (start_ack),
        .read_go     (read_go),
        .read_addr   (read_addr),
        .write_go    (write_go),
        .write_addr  (write_addr),
        .walk_clear  (walk_clear)
    );

    record_reader i_record_reader (
        .clk         (clk),
        .reset       (reset),
        .read_go     (read_go),
        .read_addr   (read_addr),
        .mem_ack     (rd_ack),
        .mem_rdata   (rd_rdata),
        .walk_clear  (walk_clear),
        .mem_req     (rd_req),
        .mem_addr    (rd_addr),
        .reader_done (reader_done),
        .list_end    (list_end),
        .next_addr   (next_addr),
        .data_valid  (data_valid),
        .data_word   (data_word),
        .list_length (list_length)
    );

    record_hash i_record_hash (
        .clk        (clk),
        .reset      (reset),
        .walk_clear (walk_clear),
        .data_valid (data_valid),
        .data_word  (data_word),
        .hash_value (hash_value),
        .data_count (data_count)
    );

    result_writer i_result_writer (
        .clk         (clk),
        .reset       (reset),
        .write_go    (write_go),
        .write_addr  (write_addr),
        .hash_value  (hash_value),
        .mem_ack     (wr_ack),
        .mem_req     (wr_req),
        .mem_addr    (wr_addr),
        .mem_wdata   (wr_wdata),
        .writer_done (writer_done)
    );

    mem_arbiter i_mem_arbiter (
        .clk       (clk),
        .reset     (reset),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_wdata  (wr_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .rd_ack    (rd_ack),
        .rd_rdata  (rd_rdata),
        .wr_ack    (wr_ack),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

endmodule

`default_nettype wire

//--- logic/mem_arbiter.sv
`default_nettype none

// Two four-phase masters share one four-phase memory port.
// The reader only reads and the writer only writes, so the grant alone
// tells the direction of the external transaction
module mem_arbiter
    import lw_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     rd_req,
    input  wire lw_addr_t rd_addr,
    input  wire logic     wr_req,
    input  wire lw_addr_t wr_addr,
    input  wire lw_word_t wr_wdata,
    input  wire logic     mem_ack,
    input  wire lw_word_t mem_rdata,
    output logic          rd_ack,
    output lw_word_t      rd_rdata,
    output logic          wr_ack,
    output logic          mem_req,
    output logic          mem_we,
    output lw_addr_t      mem_addr,
    output lw_word_t      mem_wdata
);

    logic gnt_valid;
    logic gnt_wr;
    logic gnt_req;

    // Request of whichever master holds the grant
    assign gnt_req = gnt_wr ? wr_req : rd_req;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            gnt_valid <= 1'b0;
            gnt_wr    <= 1'b0;
        end
        else if (!gnt_valid)
        begin
            // Writer wins when both ask in the same cycle
            if (wr_req || rd_req)
            begin
                gnt_valid <= 1'b1;
                gnt_wr    <= wr_req;
            end
        end
        else if (!gnt_req && !mem_ack)
        begin
            // Four-phase cycle fully closed on both sides
            gnt_valid <= 1'b0;
        end
    end

    // ========================================================================
    // Port multiplexing
    // ========================================================================

    assign mem_req   = gnt_valid && gnt_req;
    assign mem_we    = gnt_valid && gnt_wr;
    assign mem_addr  = gnt_wr ? wr_addr : rd_addr;
    assign mem_wdata = wr_wdata;

    // Ack goes back only to the granted master, without a register
    assign rd_ack   = gnt_valid && !gnt_wr && mem_ack;
    assign wr_ack   = gnt_valid && gnt_wr && mem_ack;
    assign rd_rdata = mem_rdata;

endmodule

`default_nettype wire

//--- logic/result_writer.sv
`default_nettype none

// Stores the walk result as two four-phase writes.  The hash goes to the
// word after the result address, then the flag 1 goes to the address itself
module result_writer
    import lw_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     write_go,
    input  wire lw_addr_t write_addr,
    input  wire lw_word_t hash_value,
    input  wire logic     mem_ack,
    output logic          mem_req,
    output lw_addr_t      mem_addr,
    output lw_word_t      mem_wdata,
    output logic          writer_done
);

    // FSM encoding; each write has a request phase and an ack-low phase
    localparam logic [2:0] WR_IDLE     = 3'd0;
    localparam logic [2:0] WR_HASH     = 3'd1;
    localparam logic [2:0] WR_HASH_END = 3'd2;
    localparam logic [2:0] WR_FLAG     = 3'd3;
    localparam logic [2:0] WR_FLAG_END = 3'd4;

    logic [2:0] state;
    logic       hash_phase;

    assign hash_phase = (state == WR_HASH) || (state == WR_HASH_END);

    // The write port is driven straight from the FSM state
    assign mem_req   = (state == WR_HASH) || (state == WR_FLAG);
    assign mem_addr  = hash_phase ? write_addr + 1'b1 : write_addr;
    assign mem_wdata = hash_phase ? hash_value : lw_word_t'(1);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= WR_IDLE;
            writer_done <= 1'b0;
        end
        else
        begin
            writer_done <= 1'b0;
            case (state)
                WR_IDLE:     if (write_go) state <= WR_HASH;
                WR_HASH:     if (mem_ack) state <= WR_HASH_END;
                WR_HASH_END: if (!mem_ack) state <= WR_FLAG;
                WR_FLAG:     if (mem_ack) state <= WR_FLAG_END;
                WR_FLAG_END:
                begin
                    // Flag is in memory once its ack has fallen
                    if (!mem_ack)
                    begin
                        state       <= WR_IDLE;
                        writer_done <= 1'b1;
                    end
                end
                default:     state <= WR_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/record_hash.sv
`include "lw_config.svh"

`default_nettype none

// Rotate-and-XOR hash over the data words of a walk, plus a count of them
module record_hash
    import lw_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     walk_clear,
    input  wire logic     data_valid,
    input  wire lw_word_t data_word,
    output lw_word_t      hash_value,
    output lw_addr_t      data_count
);

    lw_word_t rotated;

    // Left rotate of the running hash
    assign rotated = (hash_value << `LW_HASH_ROT) |
                     (hash_value >> (`LW_WORD_W - `LW_HASH_ROT));

    always_ff @(posedge clk)
    begin
        if (reset || walk_clear)
        begin
            hash_value <= `LW_HASH_SEED;
            data_count <= '0;
        end
        else if (data_valid)
        begin
            hash_value <= rotated ^ data_word;
            data_count <= data_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/record_reader.sv
`include "lw_config.svh"

`default_nettype none

// Reads one record word by word over a four-phase port.  Word 0 gives the
// link to the next record, the other words are passed on as data
module record_reader
    import lw_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     read_go,
    input  wire lw_addr_t read_addr,
    input  wire logic     mem_ack,
    input  wire lw_word_t mem_rdata,
    input  wire logic     walk_clear,
    output logic          mem_req,
    output lw_addr_t      mem_addr,
    output logic          reader_done,
    output logic          list_end,
    output lw_addr_t      next_addr,
    output logic          data_valid,
    output lw_word_t      data_word,
    output lw_addr_t      list_length
);

    localparam int IDX_W = $clog2(`LW_RECORD_WORDS);

    logic             busy;
    logic [IDX_W-1:0] word_idx;
    lw_addr_t         rec_addr;
    lw_record_word_t  rd_word;
    logic             link_word;
    logic             last_word;
    logic             rd_capture;

    // Read data decoded through the union
    assign rd_word = mem_rdata;

    // Words of a record sit at consecutive addresses
    assign mem_addr   = rec_addr + lw_addr_t'(word_idx);
    assign link_word  = (word_idx == '0);
    assign last_word  = (word_idx == IDX_W'(`LW_RECORD_WORDS - 1));
    assign rd_capture = mem_req && mem_ack;

    // ========================================================================
    // Transaction sequencing
    // ========================================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy        <= 1'b0;
            mem_req     <= 1'b0;
            word_idx    <= '0;
            reader_done <= 1'b0;
            data_valid  <= 1'b0;
            list_end    <= 1'b0;
            list_length <= '0;
        end
        else
        begin
            reader_done <= 1'b0;
            data_valid  <= 1'b0;

            // New walk, so forget the previous list
            if (walk_clear)
            begin
                list_length <= '0;
                list_end    <= 1'b0;
            end

            if (read_go)
            begin
                busy     <= 1'b1;
                word_idx <= '0;
                mem_req  <= 1'b1;
            end
            else if (rd_capture)
            begin
                // Read data is valid with ack; drop req to close the phase
                mem_req <= 1'b0;
                if (link_word)
                begin
                    list_length <= list_length + 1'b1;
                    list_end    <= (rd_word.link.next_addr == '0);
                end
                else
                begin
                    data_valid <= 1'b1;
                end
            end
            else if (busy && !mem_req && !mem_ack)
            begin
                // Ack has fallen, the transaction is over
                if (last_word)
                begin
                    busy        <= 1'b0;
                    reader_done <= 1'b1;
                end
                else
                begin
                    word_idx <= word_idx + 1'b1;
                    mem_req  <= 1'b1;
                end
            end
        end
    end

    // Record base, link and data word
    always_ff @(posedge clk)
    begin
        if (read_go)
        begin
            rec_addr <= read_addr;
        end
        if (rd_capture)
        begin
            if (link_word)
            begin
                next_addr <= rd_word.link.next_addr;
            end
            data_word <= rd_word.data;
        end
    end

endmodule

`default_nettype wire

//--- logic/walk_control.sv
`default_nettype none

// Top-level sequencer of one walk.  It takes the host start request,
// launches one record read after another along the chain and then lets
// the result writer store the hash and the flag
module walk_control
    import lw_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     start_req,
    input  wire lw_addr_t start_addr,
    input  wire lw_addr_t result_addr,
    input  wire logic     reader_done,
    input  wire logic     list_end,
    input  wire lw_addr_t next_addr,
    input  wire logic     writer_done,
    output logic          start_ack,
    output logic          read_go,
    output lw_addr_t      read_addr,
    output logic          write_go,
    output lw_addr_t      write_addr,
    output logic          walk_clear
);

    // FSM encoding
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_RUN   = 2'd1;
    localparam logic [1:0] ST_WRITE = 2'd2;
    localparam logic [1:0] ST_ACK   = 2'd3;

    logic [1:0] state;
    logic       start_walk;
    logic       next_record;

    // A walk begins only from idle, so start_ack is already low here
    assign start_walk  = (state == ST_IDLE) && start_req;

    // A finished record with a non-zero link leads on to the next record
    assign next_record = (state == ST_RUN) && reader_done && !list_end;

    // Acknowledge stays high for as long as the FSM waits in ST_ACK
    assign start_ack = (state == ST_ACK);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= ST_IDLE;
            read_go    <= 1'b0;
            write_go   <= 1'b0;
            walk_clear <= 1'b0;
        end
        else
        begin
            // All control outputs are single-cycle pulses
            read_go    <= 1'b0;
            write_go   <= 1'b0;
            walk_clear <= 1'b0;

            case (state)
                ST_IDLE:
                begin
                    if (start_walk)
                    begin
                        // Clear hash and counters while the first read starts
                        walk_clear <= 1'b1;
                        read_go    <= 1'b1;
                        state      <= ST_RUN;
                    end
                end
                ST_RUN:
                begin
                    if (next_record)
                    begin
                        read_go <= 1'b1;
                    end
                    else if (reader_done)
                    begin
                        // Zero link seen and the last data word is in
                        write_go <= 1'b1;
                        state    <= ST_WRITE;
                    end
                end
                ST_WRITE:
                begin
                    if (writer_done)
                    begin
                        state <= ST_ACK;
                    end
                end
                default:
                begin
                    // Hold the acknowledge until the host lets go of start_req
                    if (!start_req)
                    begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Addresses handed to the reader and the writer
    always_ff @(posedge clk)
    begin
        if (start_walk)
        begin
            read_addr  <= start_addr;
            write_addr <= result_addr;
        end
        else if (next_record)
        begin
            read_addr <= next_addr;
        end
    end

endmodule

`default_nettype wire

//--- logic/lw_pkg.sv
`include "lw_config.svh"

`default_nettype none

// ===========================================================================
// Shared types of the linked-list walker
// ===========================================================================

package lw_pkg;

    // Word address on the memory port
    typedef logic [`LW_ADDR_W-1:0] lw_addr_t;

    // One memory word, as read or written
    typedef logic [`LW_WORD_W-1:0] lw_word_t;

    // A record word read back from memory is seen in two ways.
    // Word 0 of a record is a link to the next record; only the low
    // address bits carry meaning and the upper bits are ignored.
    // Words 1 to 3 are plain data values that go into the hash
    typedef union packed
    {
        lw_word_t data;
        struct packed
        {
            logic [`LW_WORD_W-`LW_ADDR_W-1:0] unused;
            lw_addr_t                         next_addr;
        } link;
    } lw_record_word_t;

endpackage

`default_nettype wire

//--- logic/lw_config.svh
`ifndef LW_CONFIG_SVH
`define LW_CONFIG_SVH

`default_nettype none

// ===========================================================================
// Linked-list walker build constants
// ===========================================================================

// Word address width of the shared memory port
`define LW_ADDR_W 16

// Width of one memory word, which is also the hash width
`define LW_WORD_W 32

// Every record is a next pointer followed by three data words
`define LW_RECORD_WORDS 4

// Hash starting value, loaded at the start of every walk
`define LW_HASH_SEED 32'h811C9DC5

// Left-rotate applied to the running hash before each data word is mixed in
`define LW_HASH_ROT 5

`default_nettype wire

`endif
